//--- verilog/cache_pkg.sv
////////////////////
// shared types for the L1 directory
// operation codes, MESI states, way and age types
// request, lookup, update and response structs
////////////////////

package cache_pkg;

	localparam int ADDR_W   = 32;	// request address width
	localparam int OFFSET_W = 6;	// byte offset in a 64-byte line
	localparam int WAYS     = 4;

	////////////////////
	// command set, same numbering as the trace format
	typedef enum logic [3:0] {
		OP_READ  = 4'd0,	// read data request to L1 data cache
		OP_WRITE = 4'd1,	// write data request to L1 data cache
		OP_FETCH = 4'd2,	// instruction fetch
		OP_INVAL = 4'd3,	// invalidate command from L2
		OP_SNOOP = 4'd4,	// data request from L2 (snoop)
		OP_CLEAR = 4'd8		// clear the cache and reset all state
	} op_t;

	// 00 invalid, 01 shared, 10 exclusive, 11 modified
	typedef enum logic [1:0] {
		MESI_I = 2'b00,
		MESI_S = 2'b01,
		MESI_E = 2'b10,
		MESI_M = 2'b11
	} mesi_t;

	typedef logic [1:0] way_t;
	typedef logic [1:0] age_t;	// 0 = least recently used, 3 = most recently used

	typedef mesi_t [WAYS-1:0] way_states_t;	// state of each way in one set
	typedef age_t [WAYS-1:0] lru_ages_t;	// age of each way in one set

	////////////////////
	// interface structs
	typedef struct packed {
		op_t              op;
		logic [ADDR_W-1:0] addr;
	} dir_req_t;	// 36 bits

	typedef struct packed {
		logic        hit;
		way_t        hit_way;
		way_states_t way_states;
	} lookup_t;	// 11 bits

	typedef struct packed {
		logic  state_wr;	// write state and tag of one way
		way_t  way;
		mesi_t state;
		logic  touch;		// make way most recently used
		logic  clear;		// back to reset contents
	} dir_update_t;	// 7 bits

	typedef struct packed {
		logic  hit;
		way_t  way;
		mesi_t old_state;	// chosen way before the request
		mesi_t new_state;
		logic  writeback;	// modified line leaves or is handed to L2
	} dir_rsp_t;	// 8 bits

endpackage

//--- verilog/set_array.sv
////////////////////
// per-set register array with generic entry type
// combinational read, one synchronous write port
// whole-array clear
////////////////////

module set_array #(
	parameter type    entry_t   = logic [7:0],
	parameter int     DEPTH     = 16,
	parameter entry_t RESET_VAL = '0
) (
	input  logic                     clk,
	input  logic                     reset_n,
	input  logic                     clear,		// sync load of RESET_VAL everywhere
	input  logic [$clog2(DEPTH)-1:0] rd_index,
	input  logic [$clog2(DEPTH)-1:0] wr_index,
	input  logic                     wr_en,
	input  entry_t                   wr_data,
	output entry_t                   rd_data
);

	entry_t mem [DEPTH];	// one entry per set

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < DEPTH; i++) mem[i] <= RESET_VAL;
		end else if (clear) begin
			for (int i = 0; i < DEPTH; i++) mem[i] <= RESET_VAL;
		end else if (wr_en) begin
			mem[wr_index] <= wr_data;
		end
	end

	assign rd_data = mem[rd_index];	// async read, same cycle as the address

	// a clear request never carries a line write with it
	a_clear_excl_write: assert property (
		@(posedge clk) disable iff (!reset_n)
		!(clear && wr_en)
	);

endmodule

//--- verilog/way_lookup.sv
////////////////////
// tag and MESI storage for the four ways
// hit detection on the requested set
////////////////////

module way_lookup import cache_pkg::*; #(
	parameter int SET_BITS = 4
) (
	input  logic              clk,
	input  logic              reset_n,
	input  logic [ADDR_W-1:0] addr,
	input  dir_update_t       upd,
	output lookup_t           lookup
);

	localparam int TAG_W = ADDR_W - OFFSET_W - SET_BITS;
	localparam int SETS  = 1 << SET_BITS;

	// one stored line per way and set
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		mesi_t            state;
	} line_t;

	localparam line_t LINE_INIT = '{tag: '0, state: MESI_I};

	logic [SET_BITS-1:0] set_idx;
	logic [TAG_W-1:0]    addr_tag;
	line_t               rd_line [WAYS];
	line_t               wr_line;
	logic [WAYS-1:0]     match;		// per way tag hit

	assign set_idx  = addr[OFFSET_W +: SET_BITS];
	assign addr_tag = addr[ADDR_W-1 -: TAG_W];

	// invalid still keeps the tag
	assign wr_line = '{tag: addr_tag, state: upd.state};

	////////////////////
	// storage, one array per way
	for (genvar w = 0; w < WAYS; w++) begin : g_way
		set_array #(
			.entry_t   (line_t),
			.DEPTH     (SETS),
			.RESET_VAL (LINE_INIT)
		) u_lines (
			.clk      (clk),
			.reset_n  (reset_n),
			.clear    (upd.clear),
			.rd_index (set_idx),
			.wr_index (set_idx),
			.wr_en    (upd.state_wr && (upd.way == way_t'(w))),	// only the chosen way
			.wr_data  (wr_line),
			.rd_data  (rd_line[w])
		);

		assign match[w] = (rd_line[w].state != MESI_I) && (rd_line[w].tag == addr_tag);
	end

	////////////////////
	// hit and way encode
	always_comb begin
		lookup.hit     = |match;
		lookup.hit_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			lookup.way_states[w] = rd_line[w].state;
			if (match[w]) lookup.hit_way = way_t'(w);
		end
	end

	// the allocation rules must never leave two valid copies of a tag in one set
	a_single_match: assert property (
		@(posedge clk) disable iff (!reset_n)
		$onehot0(match)
	);

endmodule

//--- verilog/lru_tracker.sv
////////////////////
// LRU ages for each set
// victim selection and age update on touch
////////////////////

module lru_tracker import cache_pkg::*; #(
	parameter int SET_BITS = 4
) (
	input  logic              clk,
	input  logic              reset_n,
	input  logic [ADDR_W-1:0] addr,
	input  dir_update_t       upd,
	output way_t              victim_way
);

	localparam int SETS = 1 << SET_BITS;

	// way i starts with age i
	localparam lru_ages_t AGE_INIT = {2'd3, 2'd2, 2'd1, 2'd0};
	localparam age_t      AGE_MRU  = age_t'(WAYS - 1);

	logic [SET_BITS-1:0] set_idx;
	lru_ages_t           ages;		// addressed set, current
	lru_ages_t           ages_next;	// after a touch of upd.way
	age_t                touched_age;
	logic [WAYS-1:0]     age_seen;	// one bit per age value present

	assign set_idx = addr[OFFSET_W +: SET_BITS];

	set_array #(
		.entry_t   (lru_ages_t),
		.DEPTH     (SETS),
		.RESET_VAL (AGE_INIT)
	) u_ages (
		.clk      (clk),
		.reset_n  (reset_n),
		.clear    (upd.clear),
		.rd_index (set_idx),
		.wr_index (set_idx),
		.wr_en    (upd.touch),
		.wr_data  (ages_next),
		.rd_data  (ages)
	);

	////////////////////
	// victim = the way at age 0
	always_comb begin
		victim_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (ages[w] == '0) victim_way = way_t'(w);
		end
	end

	// touched way -> MRU, ways above its old age slide down one
	always_comb begin
		touched_age = ages[upd.way];
		age_seen    = '0;
		for (int w = 0; w < WAYS; w++) begin
			age_seen[ages[w]] = 1'b1;
			if (upd.way == way_t'(w))
				ages_next[w] = AGE_MRU;
			else if (ages[w] > touched_age)
				ages_next[w] = ages[w] - age_t'(1);
			else
				ages_next[w] = ages[w];
		end
	end

	// each access sees a full LRU order, one way per age
	a_ages_perm: assert property (
		@(posedge clk) disable iff (!reset_n)
		upd.touch |-> (&age_seen)
	);

endmodule

//--- verilog/mesi_controller.sv
////////////////////
// way choice and MESI next-state rules
// update commands to tag and LRU storage
// registered response with one cycle latency
////////////////////

module mesi_controller import cache_pkg::*; (
	input  logic        clk,
	input  logic        reset_n,
	input  logic        req_valid,
	input  dir_req_t    req,
	input  logic        shared_in,	// another cache holds the line
	input  lookup_t     lookup,
	input  way_t        victim_way,
	output dir_update_t upd,
	output logic        rsp_valid,
	output dir_rsp_t    rsp
);

	logic     op_known;	// op is in the command set
	logic     is_access;	// read, write or fetch
	way_t     alloc_way;
	mesi_t    hit_state;
	dir_rsp_t rsp_next;

	assign hit_state = lookup.way_states[lookup.hit_way];

	always_comb begin
		op_known  = 1'b0;
		is_access = 1'b0;
		case (req.op)
			OP_READ, OP_WRITE, OP_FETCH: begin
				op_known  = 1'b1;
				is_access = 1'b1;
			end
			OP_INVAL, OP_SNOOP, OP_CLEAR: op_known = 1'b1;
			default: op_known = 1'b0;	// print and unused codes are dropped
		endcase
	end

	// lowest invalid way first and the LRU victim when the set is full
	always_comb begin
		alloc_way = victim_way;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (lookup.way_states[w] == MESI_I) alloc_way = way_t'(w);
		end
	end

	////////////////////
	// next state and response
	always_comb begin
		rsp_next = '{hit: lookup.hit, way: '0, old_state: MESI_I,
			new_state: MESI_I, writeback: 1'b0};
		if (req.op == OP_CLEAR) begin
			rsp_next.hit = 1'b0;	// clear reports nothing about the line
		end else if (lookup.hit) begin
			rsp_next.way       = lookup.hit_way;
			rsp_next.old_state = hit_state;
			case (req.op)
				OP_WRITE: rsp_next.new_state = MESI_M;
				OP_INVAL: rsp_next.new_state = MESI_I;
				OP_SNOOP: begin
					rsp_next.new_state = MESI_S;		// M and E drop to shared
					rsp_next.writeback = (hit_state == MESI_M);	// dirty data goes to L2
				end
				default: rsp_next.new_state = hit_state;	// read and fetch keep state
			endcase
		end else if (is_access) begin
			// an allocating miss evicts the old contents
			rsp_next.way       = alloc_way;
			rsp_next.old_state = lookup.way_states[alloc_way];
			rsp_next.writeback = (lookup.way_states[alloc_way] == MESI_M);
			if (req.op == OP_WRITE)
				rsp_next.new_state = MESI_M;	// RFO
			else
				rsp_next.new_state = shared_in ? MESI_S : MESI_E;
		end
	end

	////////////////////
	// update commands land at the edge that ends the request cycle
	always_comb begin
		upd          = '0;
		upd.way      = rsp_next.way;
		upd.state    = rsp_next.new_state;
		if (req_valid) begin
			upd.clear    = (req.op == OP_CLEAR);
			upd.state_wr = op_known && (req.op != OP_CLEAR) && (lookup.hit || is_access);
			upd.touch    = is_access;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= req_valid && op_known;
		end
	end

	always_ff @(posedge clk) begin
		rsp <= rsp_next;	// payload that goes with rsp_valid
	end

	// a response follows its request by one cycle and never reports a hit on an invalid line
	a_rsp_follows_req: assert property (
		@(posedge clk) disable iff (!reset_n)
		rsp_valid |-> $past(req_valid) && !(rsp.hit && rsp.old_state == MESI_I)
	);

endmodule

//--- verilog/l1_directory.sv
////////////////////
// L1 directory top level, 4-way set associative
// tag lookup and LRU side by side, MESI controller on top
////////////////////

module l1_directory import cache_pkg::*; #(
	parameter int SET_BITS = 4	// 16 sets by default
) (
	input  logic     clk,
	input  logic     reset_n,
	input  logic     req_valid,	// one-cycle strobe
	input  dir_req_t req,
	input  logic     shared_in,
	output logic     rsp_valid,	// one cycle after req_valid
	output dir_rsp_t rsp
);

	lookup_t     lookup;		// hit and way states of the addressed set
	way_t        victim_way;	// LRU way of the addressed set
	dir_update_t upd;		// writes back into both parts

	////////////////////
	// tag and state storage
	way_lookup #(
		.SET_BITS (SET_BITS)
	) u_way_lookup (
		.clk     (clk),
		.reset_n (reset_n),
		.addr    (req.addr),
		.upd     (upd),
		.lookup  (lookup)
	);

	// replacement order
	lru_tracker #(
		.SET_BITS (SET_BITS)
	) u_lru_tracker (
		.clk        (clk),
		.reset_n    (reset_n),
		.addr       (req.addr),
		.upd        (upd),
		.victim_way (victim_way)
	);

	////////////////////
	// protocol decisions and response
	mesi_controller u_mesi_controller (
		.clk        (clk),
		.reset_n    (reset_n),
		.req_valid  (req_valid),
		.req        (req),
		.shared_in  (shared_in),
		.lookup     (lookup),
		.victim_way (victim_way),
		.upd        (upd),
		.rsp_valid  (rsp_valid),
		.rsp        (rsp)
	);

endmodule

//--- verif/tb_clock.sv
////////////////////
// testbench clock and reset generator
// reset held low for a fixed number of cycles
////////////////////

module tb_clock #(
	parameter int PERIOD       = 10,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic reset_n
);

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;	// free running

	initial begin
		reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset_n <= 1'b1;	// release on a rising edge
	end

endmodule

//--- verif/l1_directory_tb.sv
////////////////////
// directed tests for the L1 directory
// reference model of tags, MESI states and LRU ages
// compare tasks, LFSR stimulus and cycle timeout
////////////////////

module l1_directory_tb import cache_pkg::*;;

	localparam int SET_BITS     = 4;
	localparam int SETS         = 1 << SET_BITS;
	localparam int TAG_W        = ADDR_W - OFFSET_W - SET_BITS;
	localparam int RESET_CYCLES = 4;
	localparam int NUM_REQS     = 4 + 3 + 6 + 48 + 3;	// requests of tests 1 to 5
	// 2 cycles per request, doubled, plus reset and a margin
	localparam int TIMEOUT_CYCLES = 2 * (NUM_REQS * 2) + RESET_CYCLES + 20;

	logic     clk;
	logic     reset_n;
	logic     req_valid;
	dir_req_t req;
	logic     shared_in;
	logic     rsp_valid;
	dir_rsp_t rsp;

	// reference model
	logic [TAG_W-1:0] m_tag   [SETS][WAYS];
	mesi_t            m_state [SETS][WAYS];
	age_t             m_age   [SETS][WAYS];

	logic [31:0]      lfsr = 32'h732f_207f;
	logic [TAG_W-1:0] tag_a;
	logic [TAG_W-1:0] tag_b;
	int err_count    = 0;
	int checks       = 0;
	int tests_run    = 0;
	int tests_failed = 0;
	int cycle_count  = 0;

	tb_clock #(
		.PERIOD       (10),
		.RESET_CYCLES (RESET_CYCLES)
	) u_clock (
		.clk     (clk),
		.reset_n (reset_n)
	);

	l1_directory #(.SET_BITS(SET_BITS)) DUT (
		.clk       (clk),
		.reset_n   (reset_n),
		.req_valid (req_valid),
		.req       (req),
		.shared_in (shared_in),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

	////////////////////
	// helpers
	function automatic logic [31:0] take_bits(input int n);	// one LFSR step per bit
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};	// x^32+x^22+x^2+x+1
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] tag,
			input int set);
		return {tag, SET_BITS'(set), OFFSET_W'(0)};	// line aligned
	endfunction

	task automatic reset_model();
		for (int s = 0; s < SETS; s++) begin
			for (int w = 0; w < WAYS; w++) begin
				m_tag[s][w]   = '0;
				m_state[s][w] = MESI_I;
				m_age[s][w]   = age_t'(w);	// way i has age i
			end
		end
	endtask

	task automatic promote_way(input int set, input int way);
		age_t old_age;
		old_age = m_age[set][way];
		for (int w = 0; w < WAYS; w++) begin
			if (w == way)
				m_age[set][w] = 2'd3;	// most recently used
			else if (m_age[set][w] > old_age)
				m_age[set][w] = m_age[set][w] - 2'd1;
		end
	endtask

	// expected response of one request and the model update it implies
	task automatic predict_rsp(input logic [3:0] op, input logic [ADDR_W-1:0] addr,
			input logic sh, output logic exp_valid, output dir_rsp_t exp);
		int               set;
		int               way;
		logic [TAG_W-1:0] tag;
		logic             hit;
		logic             access;
		set       = int'(addr[OFFSET_W +: SET_BITS]);
		tag       = addr[ADDR_W-1 -: TAG_W];
		exp       = '{hit: 1'b0, way: '0, old_state: MESI_I, new_state: MESI_I,
			writeback: 1'b0};
		exp_valid = op inside {4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd8};
		access    = op inside {4'd0, 4'd1, 4'd2};	// read, write, fetch
		hit       = 1'b0;
		way       = 0;
		for (int w = 0; w < WAYS; w++) begin
			if (m_state[set][w] != MESI_I && m_tag[set][w] == tag) begin
				hit = 1'b1;
				way = w;
			end
		end
		if (op == 4'd8) begin
			reset_model();
		end else if (exp_valid && hit) begin
			exp.hit       = 1'b1;
			exp.way       = way_t'(way);
			exp.old_state = m_state[set][way];
			case (op)
				4'd1: exp.new_state = MESI_M;
				4'd3: exp.new_state = MESI_I;	// tag stays
				4'd4: begin
					exp.new_state = MESI_S;
					exp.writeback = (exp.old_state == MESI_M);
				end
				default: exp.new_state = exp.old_state;
			endcase
			m_state[set][way] = exp.new_state;
		end else if (access) begin
			way = -1;
			for (int w = 0; w < WAYS; w++) begin
				if (way < 0 && m_state[set][w] == MESI_I) way = w;	// lowest invalid
			end
			for (int w = 0; w < WAYS; w++) begin
				if (way < 0 && m_age[set][w] == 2'd0) way = w;	// LRU victim
			end
			exp.way       = way_t'(way);
			exp.old_state = m_state[set][way];
			exp.writeback = (m_state[set][way] == MESI_M);
			exp.new_state = (op == 4'd1) ? MESI_M : (sh ? MESI_S : MESI_E);
			m_tag[set][way]   = tag;
			m_state[set][way] = exp.new_state;
		end
		if (exp_valid && access) promote_way(set, way);
	endtask

	////////////////////
	// compare tasks
	function automatic string rsp_text(input dir_rsp_t r);
		return $sformatf("hit %b way %0d old %0d new %0d wb %b",
			r.hit, r.way, r.old_state, r.new_state, r.writeback);
	endfunction

	task automatic compare_flag(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			err_count++;
			$display("Mismatch %s: rsp_valid expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic compare_rsp(input string name, input dir_rsp_t exp, input dir_rsp_t act);
		checks++;
		if (act !== exp) begin
			err_count++;
			$display("Mismatch %s: expected %s, actual %s", name, rsp_text(exp),
				rsp_text(act));
		end
	endtask

	// drives one request and checks the response one cycle later
	task automatic issue(input string name, input logic [3:0] op,
			input logic [ADDR_W-1:0] addr, input logic sh, output dir_rsp_t got);
		logic     exp_valid;
		dir_rsp_t exp;
		@(posedge clk);
		req_valid <= 1'b1;
		req       <= '{op: op_t'(op), addr: addr};
		shared_in <= sh;
		predict_rsp(op, addr, sh, exp_valid, exp);
		@(posedge clk);
		req_valid <= 1'b0;
		@(negedge clk);	// response stable here
		got = rsp;
		compare_flag(name, exp_valid, rsp_valid);
		if (exp_valid) compare_rsp(name, exp, rsp);
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (err_count > errs_before) begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, err_count - errs_before);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	////////////////////
	// directed tests
	task automatic miss_alloc_hit();
		int       e;
		dir_rsp_t r;
		e     = err_count;
		tag_a = TAG_W'(take_bits(TAG_W));
		tag_b = tag_a ^ TAG_W'(1);	// distinct tag in the same set
		issue("miss_alloc_hit", 4'd0, make_addr(tag_a, 1), 1'b0, r);
		compare_rsp("miss_alloc_hit", '{hit: 1'b0, way: 2'd0, old_state: MESI_I,
			new_state: MESI_E, writeback: 1'b0}, r);
		issue("miss_alloc_hit", 4'd0, make_addr(tag_b, 1), 1'b1, r);
		compare_rsp("miss_alloc_hit", '{hit: 1'b0, way: 2'd1, old_state: MESI_I,
			new_state: MESI_S, writeback: 1'b0}, r);
		issue("miss_alloc_hit", 4'd0, make_addr(tag_a, 1), 1'b1, r);	// repeat read hits
		issue("miss_alloc_hit", 4'd2, make_addr(tag_b, 1), 1'b0, r);	// fetch keeps S
		report_test("miss_alloc_hit", e);
	endtask

	task automatic write_rules();
		int       e;
		dir_rsp_t r;
		e = err_count;
		issue("write_rules", 4'd1, make_addr(tag_a, 1), 1'b0, r);	// E -> M
		issue("write_rules", 4'd1, make_addr(tag_b, 1), 1'b0, r);	// S -> M
		issue("write_rules", 4'd1, make_addr(tag_a ^ TAG_W'(2), 1), 1'b1, r);	// miss -> M
		report_test("write_rules", e);
	endtask

	task automatic snoop_inval();
		int       e;
		dir_rsp_t r;
		e = err_count;
		issue("snoop_inval", 4'd4, make_addr(tag_a, 1), 1'b0, r);	// M -> S with writeback
		issue("snoop_inval", 4'd0, make_addr(tag_a, 2), 1'b0, r);
		issue("snoop_inval", 4'd4, make_addr(tag_a, 2), 1'b0, r);	// E -> S
		issue("snoop_inval", 4'd3, make_addr(tag_b, 1), 1'b0, r);	// M -> I
		issue("snoop_inval", 4'd4, make_addr(tag_a ^ TAG_W'(8), 2), 1'b0, r);	// misses
		issue("snoop_inval", 4'd3, make_addr(tag_a ^ TAG_W'(8), 2), 1'b0, r);
		report_test("snoop_inval", e);
	endtask

	task automatic lru_replace();
		int               e;
		dir_rsp_t         r;
		logic [3:0]       op;
		logic [TAG_W-1:0] tag;
		e = err_count;
		// fill ways 0 to 3 in order, way 1 written dirty
		for (int i = 0; i < 4; i++) begin
			op = (i == 1) ? 4'd1 : 4'd0;
			issue("lru_replace", op, make_addr(tag_a ^ TAG_W'(i), 5), 1'b0, r);
		end
		// touch every way but way 1 again
		for (int i = 0; i < 4; i++) begin
			if (i != 1)
				issue("lru_replace", 4'd0, make_addr(tag_a ^ TAG_W'(i), 5), 1'b0, r);
		end
		issue("lru_replace", 4'd0, make_addr(tag_a ^ TAG_W'(4), 5), 1'b0, r);
		compare_rsp("lru_replace", '{hit: 1'b0, way: 2'd1, old_state: MESI_M,
			new_state: MESI_E, writeback: 1'b1}, r);
		// 8 tags over 4 sets give a mix of hits and evictions
		for (int i = 0; i < 40; i++) begin
			op  = 4'(take_bits(3) % 5);
			tag = {tag_b[TAG_W-1:3], 3'(take_bits(3))};
			issue("lru_random", op, make_addr(tag, int'(take_bits(2))), take_bits(1) == 1, r);
		end
		report_test("lru_replace", e);
	endtask

	task automatic clear_unknown();
		int       e;
		dir_rsp_t r;
		e = err_count;
		issue("clear_unknown", 4'd8, make_addr(tag_a, 0), 1'b0, r);
		issue("clear_unknown", 4'd0, make_addr(tag_a, 5), 1'b0, r);	// was cached before
		compare_rsp("clear_unknown", '{hit: 1'b0, way: 2'd0, old_state: MESI_I,
			new_state: MESI_E, writeback: 1'b0}, r);
		issue("clear_unknown", 4'd9, make_addr(tag_a, 5), 1'b0, r);	// no response
		report_test("clear_unknown", e);
	endtask

	////////////////////
	// run control
	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		req_valid = 1'b0;
		req       = '0;
		shared_in = 1'b0;
		reset_model();
		wait (reset_n === 1'b1);
		miss_alloc_hit();
		write_rules();
		snoop_inval();
		lru_replace();
		clear_unknown();
		$display("tests run %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, err_count);
		if (err_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- l1_directory.f
verilog/cache_pkg.sv
verilog/set_array.sv
verilog/way_lookup.sv
verilog/lru_tracker.sv
verilog/mesi_controller.sv
verilog/l1_directory.sv
verif/tb_clock.sv
verif/l1_directory_tb.sv

//--- Makefile
# Verilator build for the L1 directory testbench
VERILATOR ?= verilator
TOP       ?= l1_directory_tb
FILELIST  ?= l1_directory.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; echo "simulator exit status $$?" >> $(LOG)
	@cat $(LOG)
	@if grep -q -F '** FAIL **' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q 'simulator exit status 0' $(LOG); then echo "simulator error"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
